//--- design/simd_alu_pkg.sv
package simd_alu_pkg;

	// Data path geometry
	localparam int unsigned word_bits = 64;
	localparam int unsigned lane_bits = 8;
	localparam int unsigned num_lanes = word_bits / lane_bits;

	// Plain vectors
	typedef logic [word_bits-1:0] word_t;
	typedef logic [lane_bits-1:0] lane_t;
	typedef logic [5:0]           opcode_t;
	typedef logic [5:0]           rfunc_t;

	// Major opcode of R-type ALU instructions
	localparam opcode_t op_r_alu = 6'b101010;

	// R-type function field
	localparam rfunc_t rf_vand   = 6'b000001;
	localparam rfunc_t rf_vor    = 6'b000010;
	localparam rfunc_t rf_vxor   = 6'b000011;
	localparam rfunc_t rf_vnot   = 6'b000100;
	localparam rfunc_t rf_vmov   = 6'b000101;
	localparam rfunc_t rf_vadd   = 6'b000110;
	localparam rfunc_t rf_vsub   = 6'b000111;
	// Even multiply, not executed here
	localparam rfunc_t rf_vmuleu = 6'b001000;

	// Element width, encoded as the WW field
	typedef enum logic [1:0] {
		w8  = 2'b00,
		w16 = 2'b01,
		w32 = 2'b10,
		w64 = 2'b11
	} elem_width_e;

	// Decoded function seen by the lanes
	typedef enum logic [2:0] {
		fn_none = 3'd0,
		fn_and  = 3'd1,
		fn_or   = 3'd2,
		fn_xor  = 3'd3,
		fn_not  = 3'd4,
		fn_mov  = 3'd5,
		fn_add  = 3'd6,
		fn_sub  = 3'd7
	} alu_fn_e;

	// Four-phase handshake sequencing
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_exec = 2'd1,
		st_ack  = 2'd2
	} issue_state_e;

	// Command broadcast to every lane
	typedef struct packed {
		alu_fn_e     fn;
		elem_width_e width;
	} alu_cmd_t;

	// One byte of each operand
	typedef struct packed {
		lane_t a;
		lane_t b;
	} lane_operands_t;

endpackage

//--- design/alu_issue.sv
module alu_issue (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        req,
	output logic                        ack,
	input  simd_alu_pkg::word_t         a,
	input  simd_alu_pkg::word_t         b,
	input  simd_alu_pkg::opcode_t       op_code,
	input  simd_alu_pkg::rfunc_t        r_ins,
	input  simd_alu_pkg::elem_width_e   ww,
	output simd_alu_pkg::alu_cmd_t      cmd,
	output simd_alu_pkg::lane_operands_t [simd_alu_pkg::num_lanes-1:0] operands,
	output logic                        capture,
	output logic                        err
);

	import simd_alu_pkg::*;

	issue_state_e state;
	issue_state_e state_next;
	alu_fn_e      fn_dec;
	logic         load;

	// Function decode of the incoming instruction
	always_comb begin
		fn_dec = fn_none;
		if (op_code == op_r_alu) begin
			case (r_ins)
				rf_vand: fn_dec = fn_and;
				rf_vor:  fn_dec = fn_or;
				rf_vxor: fn_dec = fn_xor;
				rf_vnot: fn_dec = fn_not;
				rf_vmov: fn_dec = fn_mov;
				rf_vadd: fn_dec = fn_add;
				rf_vsub: fn_dec = fn_sub;
				default: fn_dec = fn_none;
			endcase
		end
	end

	// Instruction is taken on the first edge that sees req in idle
	assign load = (state == st_idle) && req;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (req) begin
					state_next = st_exec;
				end
			end
			st_exec: begin
				state_next = st_ack;
			end
			st_ack: begin
				// Hold the result until the host drops req
				if (!req) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// Command and error flag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd.fn    <= fn_none;
			cmd.width <= w8;
			err       <= 1'b0;
		end else if (load) begin
			cmd.fn    <= fn_dec;
			cmd.width <= ww;
			err       <= (fn_dec == fn_none);
		end
	end

	// Operand bytes, lane 0 is the low byte
	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < num_lanes; i++) begin
				operands[i].a <= a[i*lane_bits +: lane_bits];
				operands[i].b <= b[i*lane_bits +: lane_bits];
			end
		end
	end

	// Lanes settle during st_exec, collector samples on the next edge
	assign capture = (state == st_exec);
	assign ack     = (state == st_ack);

endmodule

//--- design/alu_byte_lane.sv
module alu_byte_lane #(
	parameter int unsigned lane_idx = 0
) (
	input  simd_alu_pkg::alu_cmd_t       cmd,
	input  simd_alu_pkg::lane_operands_t operands,
	input  logic                         carry_in,
	output simd_alu_pkg::lane_t          lane_result,
	output logic                         carry_out
);

	import simd_alu_pkg::*;

	logic                elem_start;
	logic                is_sub;
	logic                cin;
	lane_t               b_eff;
	logic [lane_bits:0]  sum;

	// Does this lane hold the low byte of an element
	always_comb begin
		case (cmd.width)
			w8:      elem_start = 1'b1;
			w16:     elem_start = (lane_idx % 2) == 0;
			w32:     elem_start = (lane_idx % 4) == 0;
			w64:     elem_start = (lane_idx == 0);
			default: elem_start = 1'b1;
		endcase
	end

	assign is_sub = (cmd.fn == fn_sub);

	// Two's complement subtract, a + ~b + 1 at the element base
	assign b_eff = is_sub ? ~operands.b : operands.b;
	assign cin   = elem_start ? is_sub : carry_in;

	assign sum       = {1'b0, operands.a} + {1'b0, b_eff} + {{lane_bits{1'b0}}, cin};
	assign carry_out = sum[lane_bits];

	always_comb begin
		case (cmd.fn)
			fn_and:  lane_result = operands.a & operands.b;
			fn_or:   lane_result = operands.a | operands.b;
			fn_xor:  lane_result = operands.a ^ operands.b;
			fn_not:  lane_result = ~operands.a;
			fn_mov:  lane_result = operands.a;
			fn_add:  lane_result = sum[lane_bits-1:0];
			fn_sub:  lane_result = sum[lane_bits-1:0];
			// Unsupported instruction yields a zero word
			default: lane_result = '0;
		endcase
	end

endmodule

//--- design/alu_result_collect.sv
module alu_result_collect (
	input  logic                                             clk,
	input  logic                                             arst_n,
	input  logic                                             capture,
	input  simd_alu_pkg::lane_t [simd_alu_pkg::num_lanes-1:0] lane_result,
	output simd_alu_pkg::word_t                              result,
	output logic                                             rz
);

	import simd_alu_pkg::*;

	word_t lane_word;

	// Lane 0 ends up in bits 7:0
	always_comb begin
		lane_word = '0;
		for (int i = 0; i < num_lanes; i++) begin
			lane_word[i*lane_bits +: lane_bits] = lane_result[i];
		end
	end

	// Word and zero flag are taken together and held until the next capture
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
			rz     <= 1'b1;
		end else if (capture) begin
			result <= lane_word;
			rz     <= (lane_word == '0);
		end
	end

endmodule

//--- design/simd_alu.sv
module simd_alu (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      req,
	output logic                      ack,
	input  simd_alu_pkg::word_t       a,
	input  simd_alu_pkg::word_t       b,
	input  simd_alu_pkg::opcode_t     op_code,
	input  simd_alu_pkg::rfunc_t      r_ins,
	input  simd_alu_pkg::elem_width_e ww,
	output simd_alu_pkg::word_t       result,
	output logic                      rz,
	output logic                      err
);

	import simd_alu_pkg::*;

	alu_cmd_t                        cmd;
	lane_operands_t [num_lanes-1:0]  operands;
	lane_t          [num_lanes-1:0]  lane_result;
	logic           [num_lanes-1:0]  carry_in;
	logic           [num_lanes-1:0]  carry_out;
	logic                            capture;

	alu_issue u_issue (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.ack      (ack),
		.a        (a),
		.b        (b),
		.op_code  (op_code),
		.r_ins    (r_ins),
		.ww       (ww),
		.cmd      (cmd),
		.operands (operands),
		.capture  (capture),
		.err      (err)
	);

	// Carry ripples upward, lane 0 starts from zero
	assign carry_in = {carry_out[num_lanes-2:0], 1'b0};

	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		alu_byte_lane #(
			.lane_idx (i)
		) u_lane (
			.cmd         (cmd),
			.operands    (operands[i]),
			.carry_in    (carry_in[i]),
			.lane_result (lane_result[i]),
			.carry_out   (carry_out[i])
		);
	end

	alu_result_collect u_collect (
		.clk         (clk),
		.arst_n      (arst_n),
		.capture     (capture),
		.lane_result (lane_result),
		.result      (result),
		.rz          (rz)
	);

endmodule

//--- dv/simd_alu_tb.sv
module simd_alu_tb;

	timeunit 1ns;
	timeprecision 10ps;

	import simd_alu_pkg::*;

	// Up to 250 transactions of 6 cycles plus up to 4 cycles of held req,
	// with room for reset and the drain at the end
	localparam int max_txns    = 250;
	localparam int txn_cycles  = 10;
	localparam int cycle_limit = max_txns * txn_cycles + 500;

	logic        clk;
	logic        arst_n;
	logic        req;
	logic        ack;
	word_t       a;
	word_t       b;
	opcode_t     op_code;
	rfunc_t      r_ins;
	elem_width_e ww;
	word_t       result;
	logic        rz;
	logic        err;

	word_t       exp_result;
	logic        exp_rz;
	logic        exp_err;
	int          cycle_count;
	int          txn_count;
	int          errors;
	logic [31:0] rng_state;

	rfunc_t logic_fns [5] = '{rf_vand, rf_vor, rf_vxor, rf_vnot, rf_vmov};

	simd_alu simd_alu_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.ack     (ack),
		.a       (a),
		.b       (b),
		.op_code (op_code),
		.r_ins   (r_ins),
		.ww      (ww),
		.result  (result),
		.rz      (rz),
		.err     (err)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the run did not complete", cycle_count);
			$display("transactions %0d, errors %0d", txn_count, errors + 1);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic next_rand(output word_t w);
		rng_state = xorshift(rng_state);
		w[63:32] = rng_state;
		rng_state = xorshift(rng_state);
		w[31:0] = rng_state;
	endtask

	function automatic int unsigned elem_bits(input elem_width_e w);
		return 8 << int'(w);
	endfunction

	// Ones in the low element only
	function automatic word_t low_elem_mask(input elem_width_e w);
		if (elem_bits(w) == 64) begin
			return '1;
		end
		return (word_t'(1) << elem_bits(w)) - 1;
	endfunction

	// Value 1 in every element
	function automatic word_t ones_per_elem(input elem_width_e w);
		word_t r;
		r = '0;
		for (int unsigned base = 0; base < 64; base += elem_bits(w)) begin
			r[base] = 1'b1;
		end
		return r;
	endfunction

	function automatic logic ref_err(input opcode_t op, input rfunc_t fn);
		if (op != op_r_alu) begin
			return 1'b1;
		end
		return !(fn inside {rf_vand, rf_vor, rf_vxor, rf_vnot, rf_vmov, rf_vadd, rf_vsub});
	endfunction

	// Element-wise arithmetic modulo 2 to the element size
	function automatic word_t ref_result(input opcode_t op, input rfunc_t fn,
			input elem_width_e w, input word_t x, input word_t y);
		word_t mask;
		word_t ea;
		word_t eb;
		word_t es;
		word_t r;
		r = '0;
		mask = low_elem_mask(w);
		if (ref_err(op, fn)) begin
			return '0;
		end
		case (fn)
			rf_vand: r = x & y;
			rf_vor:  r = x | y;
			rf_vxor: r = x ^ y;
			rf_vnot: r = ~x;
			rf_vmov: r = x;
			default: begin
				for (int unsigned base = 0; base < 64; base += elem_bits(w)) begin
					ea = (x >> base) & mask;
					eb = (y >> base) & mask;
					es = (fn == rf_vadd) ? (ea + eb) : (ea - eb);
					r = r | ((es & mask) << base);
				end
			end
		endcase
		return r;
	endfunction

	// One four-phase transaction with req held for hold extra cycles after ack
	task automatic run_txn(input opcode_t op, input rfunc_t fn, input elem_width_e w,
			input word_t x, input word_t y, input int hold);
		word_t r;
		r = ref_result(op, fn, w, x, y);
		@(posedge clk);
		a          <= x;
		b          <= y;
		op_code    <= op;
		r_ins      <= fn;
		ww         <= w;
		exp_result <= r;
		exp_rz     <= (r == '0);
		exp_err    <= ref_err(op, fn);
		req        <= 1'b1;
		do @(posedge clk); while (ack !== 1'b1);
		repeat (hold) @(posedge clk);
		req <= 1'b0;
		do @(posedge clk); while (ack !== 1'b0);
		txn_count++;
	endtask

	// Reset values during reset and at the first edge after release
	assert property (@(posedge clk)
			(cycle_count > 0 && (!arst_n || $rose(arst_n))) |-> ack == 1'b0)
	else begin
		errors++;
		$display("mismatch at %0t: ack expected 0 actual %b", $time, $sampled(ack));
	end
	assert property (@(posedge clk)
			(cycle_count > 0 && (!arst_n || $rose(arst_n))) |-> result == '0)
	else begin
		errors++;
		$display("mismatch at %0t: result expected 0 actual %h", $time, $sampled(result));
	end
	assert property (@(posedge clk)
			(cycle_count > 0 && (!arst_n || $rose(arst_n))) |-> rz == 1'b1)
	else begin
		errors++;
		$display("mismatch at %0t: rz expected 1 actual %b", $time, $sampled(rz));
	end
	assert property (@(posedge clk)
			(cycle_count > 0 && (!arst_n || $rose(arst_n))) |-> err == 1'b0)
	else begin
		errors++;
		$display("mismatch at %0t: err expected 0 actual %b", $time, $sampled(err));
	end

	// Handshake timing
	assert property (@(posedge clk) disable iff (!arst_n) $rose(req) |-> !ack ##1 !ack ##1 ack)
	else begin
		errors++;
		$display("at %0t: ack did not rise exactly two edges after req was seen", $time);
	end
	assert property (@(posedge clk) disable iff (!arst_n)
			(ack && req) |=> (ack && $stable(result) && $stable(rz) && $stable(err)))
	else begin
		errors++;
		$display("at %0t: ack or outputs changed while req was held high", $time);
	end
	assert property (@(posedge clk) disable iff (!arst_n) (ack && !req) |=> !ack)
	else begin
		errors++;
		$display("at %0t: ack did not fall after req was dropped", $time);
	end
	assert property (@(posedge clk) disable iff (!arst_n) (!ack && !req) |=> !ack)
	else begin
		errors++;
		$display("at %0t: ack rose without a request", $time);
	end

	// Completed transaction against the model
	assert property (@(posedge clk) disable iff (!arst_n) $rose(ack) |-> result == exp_result)
	else begin
		errors++;
		$display("mismatch at %0t: result expected %h actual %h",
			$time, $sampled(exp_result), $sampled(result));
	end
	assert property (@(posedge clk) disable iff (!arst_n) $rose(ack) |-> rz == exp_rz)
	else begin
		errors++;
		$display("mismatch at %0t: rz expected %b actual %b",
			$time, $sampled(exp_rz), $sampled(rz));
	end
	assert property (@(posedge clk) disable iff (!arst_n) $rose(ack) |-> err == exp_err)
	else begin
		errors++;
		$display("mismatch at %0t: err expected %b actual %b",
			$time, $sampled(exp_err), $sampled(err));
	end

	initial begin : main_seq
		word_t       x;
		word_t       y;
		word_t       t;
		opcode_t     op;
		elem_width_e w;
		arst_n      = 1'b0;
		req         = 1'b0;
		a           = '0;
		b           = '0;
		op_code     = '0;
		r_ins       = '0;
		ww          = w8;
		exp_result  = '0;
		exp_rz      = 1'b1;
		exp_err     = 1'b0;
		cycle_count = 0;
		txn_count   = 0;
		errors      = 0;
		rng_state   = 32'ha917;

		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// Logic functions ignore ww
		for (int f = 0; f < 5; f++) begin
			for (int wi = 0; wi < 4; wi++) begin
				for (int n = 0; n < 4; n++) begin
					next_rand(x);
					next_rand(y);
					next_rand(t);
					run_txn(op_r_alu, logic_fns[f], elem_width_e'(wi), x, y, int'(t[1:0]));
				end
			end
		end

		// Random add and subtract at every width
		for (int wi = 0; wi < 4; wi++) begin
			w = elem_width_e'(wi);
			for (int n = 0; n < 12; n++) begin
				next_rand(x);
				next_rand(y);
				next_rand(t);
				run_txn(op_r_alu, n[0] ? rf_vsub : rf_vadd, w, x, y, int'(t[1:0]));
			end
		end

		// Wrap inside each element without touching its neighbors
		for (int wi = 0; wi < 4; wi++) begin
			w = elem_width_e'(wi);
			run_txn(op_r_alu, rf_vadd, w, '1, ones_per_elem(w), 0);
			run_txn(op_r_alu, rf_vsub, w, '0, ones_per_elem(w), 1);
			run_txn(op_r_alu, rf_vadd, w, low_elem_mask(w), 64'h1, 4);
			run_txn(op_r_alu, rf_vsub, w, '0, 64'h1, 0);
			next_rand(x);
			run_txn(op_r_alu, rf_vsub, w, x, x, 2);
		end

		// Unsupported opcodes and function codes
		for (int n = 0; n < 6; n++) begin
			next_rand(x);
			next_rand(y);
			op = x[5:0];
			if (op == op_r_alu) begin
				op = op ^ 6'h01;
			end
			run_txn(op, rf_vadd, elem_width_e'(y[1:0]), x, y, n % 4);
		end
		for (int wi = 0; wi < 4; wi++) begin
			next_rand(x);
			next_rand(y);
			run_txn(op_r_alu, rf_vmuleu, elem_width_e'(wi), x, y, wi);
		end

		repeat (3) @(posedge clk);
		$display("transactions %0d, errors %0d", txn_count, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- all.f
design/simd_alu_pkg.sv
design/alu_issue.sv
design/alu_byte_lane.sv
design/alu_result_collect.sv
design/simd_alu.sv
dv/simd_alu_tb.sv

//--- Bender.yml
package:
  name: simd_alu

sources:
  - files:
      - design/simd_alu_pkg.sv
      - design/alu_issue.sv
      - design/alu_byte_lane.sv
      - design/alu_result_collect.sv
      - design/simd_alu.sv
  - target: simulation
    files:
      - dv/simd_alu_tb.sv
